// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// fetch queue entries
// also the fetch credits granted after reset
`define FQ_DEPTH 4

// decode buffer entries
// also the slot-link credits the fetch queue starts with
`define DEC_DEPTH 2

// issue-side credits held by the decode stage after reset
`define OUT_CREDITS 2

`endif

// File: cpuPkg.sv
package cpuPkg;

    // alu operation selected by the decoder
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluLui,
        aluNone
    } aluOp;

    // per-instruction control signals
    typedef struct packed {
        aluOp alu;
        logic useImm;
        logic regWrite;
        logic memRead;
        logic memWrite;
        // conditional branch (beq, bne)
        logic branch;
        // unconditional jump (j, jal, jr)
        logic jump;
        // writes return address to r31
        logic link;
        logic cp0Read;
        logic cp0Write;
        // valid lane with an unsupported encoding
        logic reserved;
    } ctlBundle;

    // one fetch packet, lane 1 is the older instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [1:0][31:0] instr;
        logic [1:0] laneValid;
    } fetchPacket;

    // one decoded instruction
    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] rawInstr;
        logic [15:0] imm;
        // {rd, sel}
        logic [7:0] cp0ra;
        logic [4:0] ra1;
        logic [4:0] ra2;
        logic [4:0] rdst;
        logic isSlot;
        ctlBundle ctl;
    } decodedLane;

    // index 1 is the older lane
    typedef decodedLane [1:0] decodedPair;

endpackage

// File: slotIf.sv
`timescale 1ns/1ps

// link between fetch queue and decode stage
// credit based, no ready signal
interface slotIf;
    import cpuPkg::*;

    // one cycle per packet sent
    logic valid;
    fetchPacket pkt;
    // one pulse per decode buffer entry freed
    logic credit;

    // fetch queue side
    modport sender (
        output valid,
        output pkt,
        input  credit
    );

    // decode stage side
    modport receiver (
        input  valid,
        input  pkt,
        output credit
    );

endinterface

// File: creditFifo.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module creditFifo #(
    parameter int DEPTH = `FQ_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  cpuPkg::fetchPacket inPkt,
    output logic fetchCredit,
    slotIf.sender slot
);
    import cpuPkg::*;

    localparam int ptrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cntW = $clog2(DEPTH + 1);
    localparam int crdW = $clog2(`DEC_DEPTH + 1);

    fetchPacket mem [DEPTH];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic [crdW-1:0] slotCredits;
    logic pop;

    // head goes out as soon as it exists and decode has room
    assign pop = (count != '0) && (slotCredits != '0);
    assign slot.valid = pop;
    assign slot.pkt = mem[rdPtr];
    // every pop frees a queue entry for the fetch unit
    assign fetchCredit = pop;

    // payload storage
    always_ff @(posedge clk) begin
        if (inValid) begin
            mem[wrPtr] <= inPkt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            slotCredits <= crdW'(`DEC_DEPTH);
        end else begin
            if (inValid) begin
                wrPtr <= (wrPtr == ptrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + cntW'(inValid) - cntW'(pop);
            // credit back from decode may coincide with a send
            slotCredits <= slotCredits + crdW'(slot.credit) - crdW'(pop);
        end
    end

    // fetch unit must respect the credits handed out
    pushNotFull: assert property (@(posedge clk) disable iff (rst)
        inValid |-> count < DEPTH);

    // decode stage never returns more than it was given
    slotCreditBound: assert property (@(posedge clk) disable iff (rst)
        slotCredits <= `DEC_DEPTH);

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic valid,
    input  logic [31:0] instr,
    output cpuPkg::ctlBundle ctl,
    output logic [4:0] srcRegA,
    output logic [4:0] srcRegB,
    output logic [4:0] destReg,
    output logic jump
);
    import cpuPkg::*;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opJ = 6'b000010;
    localparam logic [5:0] opJal = 6'b000011;
    localparam logic [5:0] opBeq = 6'b000100;
    localparam logic [5:0] opBne = 6'b000101;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opOri = 6'b001101;
    localparam logic [5:0] opLui = 6'b001111;
    localparam logic [5:0] opCop0 = 6'b010000;
    localparam logic [5:0] opLw = 6'b100011;
    localparam logic [5:0] opSw = 6'b101011;
    // funct codes under special
    localparam logic [5:0] fnJr = 6'b001000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr = 6'b100101;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnSlt = 6'b101010;
    // rs codes under cop0
    localparam logic [4:0] rsMf = 5'b00000;
    localparam logic [4:0] rsMt = 5'b00100;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic legal;

    assign opcode = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign funct = instr[5:0];

    always_comb begin
        ctl = '0;
        ctl.alu = aluNone;
        srcRegA = '0;
        srcRegB = '0;
        destReg = '0;
        legal = 1'b1;
        case (opcode)
            opSpecial: begin
                srcRegA = rs;
                srcRegB = rt;
                destReg = rd;
                ctl.regWrite = 1'b1;
                case (funct)
                    fnAddu: ctl.alu = aluAdd;
                    fnSubu: ctl.alu = aluSub;
                    fnAnd: ctl.alu = aluAnd;
                    fnOr: ctl.alu = aluOr;
                    fnXor: ctl.alu = aluXor;
                    fnSlt: ctl.alu = aluSlt;
                    fnJr: begin
                        // only rs is read, nothing written
                        ctl.jump = 1'b1;
                        ctl.regWrite = 1'b0;
                        srcRegB = '0;
                        destReg = '0;
                    end
                    default: legal = 1'b0;
                endcase
            end
            opAddiu, opOri, opLui, opLw: begin
                srcRegA = (opcode == opLui) ? 5'd0 : rs;
                destReg = rt;
                ctl.useImm = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.memRead = (opcode == opLw);
                ctl.alu = (opcode == opOri) ? aluOr : (opcode == opLui) ? aluLui : aluAdd;
            end
            opSw: begin
                // address from rs, store data from rt
                srcRegA = rs;
                srcRegB = rt;
                ctl.useImm = 1'b1;
                ctl.memWrite = 1'b1;
                ctl.alu = aluAdd;
            end
            opBeq, opBne: begin
                // compare by subtraction
                srcRegA = rs;
                srcRegB = rt;
                ctl.branch = 1'b1;
                ctl.alu = aluSub;
            end
            opJ: ctl.jump = 1'b1;
            opJal: begin
                ctl.jump = 1'b1;
                ctl.link = 1'b1;
                ctl.regWrite = 1'b1;
                destReg = 5'd31;
            end
            opCop0: begin
                case (rs)
                    // mfc0 rt, rd
                    rsMf: begin
                        ctl.cp0Read = 1'b1;
                        ctl.regWrite = 1'b1;
                        destReg = rt;
                    end
                    // mtc0 rt, rd
                    rsMt: begin
                        ctl.cp0Write = 1'b1;
                        srcRegA = rt;
                    end
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        // empty lanes and unknown encodings do nothing
        if (!valid || !legal) begin
            ctl = '0;
            ctl.alu = aluNone;
            srcRegA = '0;
            srcRegB = '0;
            destReg = '0;
        end
        ctl.reserved = valid && !legal;
    end

    // any control transfer, so the next lane is a delay slot
    assign jump = ctl.jump | ctl.branch;

endmodule

// File: dualDecode.sv
`timescale 1ns/1ps

module dualDecode (
    input  cpuPkg::fetchPacket pkt,
    output cpuPkg::decodedPair pair
);
    import cpuPkg::*;

    logic [1:0][31:0] lanePc;
    logic olderJump;

    // packet pc is aligned to the older lane
    assign lanePc[1] = pkt.pc;
    assign lanePc[0] = pkt.pc + 32'd4;

    // older lane
    instrDecoder uDecOld (
        .valid(pkt.laneValid[1]),
        .instr(pkt.instr[1]),
        .ctl(pair[1].ctl),
        .srcRegA(pair[1].ra1),
        .srcRegB(pair[1].ra2),
        .destReg(pair[1].rdst),
        .jump(olderJump)
    );

    // younger lane, its own jump flag has no consumer in this pair
    instrDecoder uDecYoung (
        .valid(pkt.laneValid[0]),
        .instr(pkt.instr[0]),
        .ctl(pair[0].ctl),
        .srcRegA(pair[0].ra1),
        .srcRegB(pair[0].ra2),
        .destReg(pair[0].rdst),
        .jump()
    );

    for (genvar i = 0; i < 2; i++) begin : gLane
        assign pair[i].valid = pkt.laneValid[i];
        assign pair[i].pc = lanePc[i];
        assign pair[i].rawInstr = pkt.instr[i];
        assign pair[i].imm = pkt.instr[i][15:0];
        // cp0 address is rd with the 3-bit sel
        assign pair[i].cp0ra = {pkt.instr[i][15:11], pkt.instr[i][2:0]};
    end

    // lane 0 sits in the delay slot of a taken-or-not transfer in lane 1
    assign pair[1].isSlot = 1'b0;
    assign pair[0].isSlot = pkt.laneValid[1] & olderJump;

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decodeStage (
    input  logic clk,
    input  logic rst,
    slotIf.receiver slot,
    output logic decValid,
    output cpuPkg::decodedPair decPair,
    input  logic decCredit
);
    import cpuPkg::*;

    localparam int bufDepth = `DEC_DEPTH;
    localparam int ptrW = (bufDepth > 1) ? $clog2(bufDepth) : 1;
    localparam int cntW = $clog2(bufDepth + 1);
    localparam int crdW = $clog2(`OUT_CREDITS + 1);

    decodedPair decoded;
    decodedPair pairBuf [bufDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic [crdW-1:0] outCredits;

    // decode in the arrival cycle
    dualDecode uDual (
        .pkt(slot.pkt),
        .pair(decoded)
    );

    // head leaves when issue holds a credit for it
    assign decValid = (count != '0) && (outCredits != '0);
    assign decPair = pairBuf[rdPtr];
    // freed buffer entry goes back to the fetch queue
    assign slot.credit = decValid;

    always_ff @(posedge clk) begin
        if (slot.valid) begin
            pairBuf[wrPtr] <= decoded;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            outCredits <= crdW'(`OUT_CREDITS);
        end else begin
            if (slot.valid) begin
                wrPtr <= (wrPtr == ptrW'(bufDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (decValid) begin
                rdPtr <= (rdPtr == ptrW'(bufDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + cntW'(slot.valid) - cntW'(decValid);
            outCredits <= outCredits + crdW'(decCredit) - crdW'(decValid);
        end
    end

    // fetch queue only sends against slot credits
    rxNotFull: assert property (@(posedge clk) disable iff (rst)
        slot.valid |-> count < bufDepth);

    // issue side never returns more credits than it was given
    outCreditBound: assert property (@(posedge clk) disable iff (rst)
        outCredits <= `OUT_CREDITS);

endmodule

// File: decodeTop.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decodeTop (
    input  logic clk,
    input  logic rst,
    input  logic fetchValid,
    input  logic [31:0] fetchPc,
    input  logic [31:0] fetchInstr1,
    input  logic [31:0] fetchInstr0,
    input  logic [1:0] fetchLaneValid,
    output logic fetchCredit,
    output logic decValid,
    output cpuPkg::decodedPair decPair,
    input  logic decCredit
);
    import cpuPkg::*;

    fetchPacket fetchPkt;

    // queue to decode link
    slotIf slotLink ();

    // lane 1 is the older word
    assign fetchPkt.pc = fetchPc;
    assign fetchPkt.instr = {fetchInstr1, fetchInstr0};
    assign fetchPkt.laneValid = fetchLaneValid;

    creditFifo #(
        .DEPTH(`FQ_DEPTH)
    ) uFetchQueue (
        .clk(clk),
        .rst(rst),
        .inValid(fetchValid),
        .inPkt(fetchPkt),
        .fetchCredit(fetchCredit),
        .slot(slotLink.sender)
    );

    decodeStage uDecode (
        .clk(clk),
        .rst(rst),
        .slot(slotLink.receiver),
        .decValid(decValid),
        .decPair(decPair),
        .decCredit(decCredit)
    );

endmodule

// File: tbDecodeTop.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tbDecodeTop;
    import cpuPkg::*;

    localparam int numPkts = 300;
    localparam int resetCycles = 10;
    localparam int stallCycles = 30;
    localparam int timeoutCycles = 40 * numPkts + resetCycles + stallCycles;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic fetchValid = 1'b0;
    logic [31:0] fetchPc = '0;
    logic [31:0] fetchInstr1 = '0;
    logic [31:0] fetchInstr0 = '0;
    logic [1:0] fetchLaneValid = '0;
    logic decCredit = 1'b0;
    logic fetchCredit;
    logic decValid;
    decodedPair decPair;

    // testbench bookkeeping
    decodedPair expQ[$];
    int fetchCreditsTb = `FQ_DEPTH;
    int outCreditsTb = `OUT_CREDITS;
    int pendingReturns = 0;
    int accepted = 0;
    int fetchPulses = 0;
    int matched = 0;
    int cycles = 0;
    // stall phase first and random traffic both ways after it
    logic driveOn = 1'b0;
    logic stallPhase = 1'b1;
    logic returnOn = 1'b0;

    decodeTop uut (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .fetchInstr1(fetchInstr1),
        .fetchInstr0(fetchInstr0),
        .fetchLaneValid(fetchLaneValid),
        .fetchCredit(fetchCredit),
        .decValid(decValid),
        .decPair(decPair),
        .decCredit(decCredit)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else failRun($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // one lane by MIPS rules and an inactive bundle for empty or unknown words
    function automatic decodedLane expectLane(input logic v, input logic [31:0] w,
                                              input logic [31:0] pc);
        decodedLane d;
        logic known;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        d = '0;
        d.ctl.alu = aluNone;
        known = 1'b1;
        case (w[31:26])
            6'h00: begin
                d.ra1 = rs;
                case (w[5:0])
                    6'h21: d.ctl.alu = aluAdd;
                    6'h23: d.ctl.alu = aluSub;
                    6'h24: d.ctl.alu = aluAnd;
                    6'h25: d.ctl.alu = aluOr;
                    6'h26: d.ctl.alu = aluXor;
                    6'h2a: d.ctl.alu = aluSlt;
                    6'h08: d.ctl.jump = 1'b1;
                    default: known = 1'b0;
                endcase
                // jr reads rs only
                if (!d.ctl.jump) begin
                    d.ra2 = rt;
                    d.rdst = rd;
                    d.ctl.regWrite = 1'b1;
                end
            end
            // addiu, ori, lui, lw all write rt
            6'h09, 6'h0d, 6'h0f, 6'h23: begin
                d.ra1 = (w[31:26] == 6'h0f) ? 5'd0 : rs;
                d.rdst = rt;
                d.ctl.useImm = 1'b1;
                d.ctl.regWrite = 1'b1;
                d.ctl.memRead = (w[31:26] == 6'h23);
                if (w[31:26] == 6'h0d) d.ctl.alu = aluOr;
                else if (w[31:26] == 6'h0f) d.ctl.alu = aluLui;
                else d.ctl.alu = aluAdd;
            end
            6'h2b: begin
                d.ra1 = rs;
                d.ra2 = rt;
                d.ctl.useImm = 1'b1;
                d.ctl.memWrite = 1'b1;
                d.ctl.alu = aluAdd;
            end
            6'h04, 6'h05: begin
                d.ra1 = rs;
                d.ra2 = rt;
                d.ctl.branch = 1'b1;
                d.ctl.alu = aluSub;
            end
            6'h02: d.ctl.jump = 1'b1;
            6'h03: begin
                d.ctl.jump = 1'b1;
                d.ctl.link = 1'b1;
                d.ctl.regWrite = 1'b1;
                d.rdst = 5'd31;
            end
            // cop0 picks mfc0 or mtc0 by rs
            6'h10: begin
                if (rs == 5'h00) begin
                    d.ctl.cp0Read = 1'b1;
                    d.ctl.regWrite = 1'b1;
                    d.rdst = rt;
                end else if (rs == 5'h04) begin
                    d.ctl.cp0Write = 1'b1;
                    d.ra1 = rt;
                end else begin
                    known = 1'b0;
                end
            end
            default: known = 1'b0;
        endcase
        if (!v || !known) begin
            d = '0;
            d.ctl.alu = aluNone;
        end
        d.ctl.reserved = v && !known;
        d.valid = v;
        d.pc = pc;
        d.rawInstr = w;
        d.imm = w[15:0];
        d.cp0ra = {rd, w[2:0]};
        return d;
    endfunction

    function automatic decodedPair refDecode(input fetchPacket p);
        decodedPair e;
        e[1] = expectLane(p.laneValid[1], p.instr[1], p.pc);
        e[0] = expectLane(p.laneValid[0], p.instr[0], p.pc + 32'd4);
        // younger lane sits behind any control transfer in the older lane
        e[0].isSlot = p.laneValid[1] && (e[1].ctl.jump || e[1].ctl.branch);
        return e;
    endfunction

    // subset instruction with random fields plus two reserved forms
    function automatic logic [31:0] randInstr();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;
        rs = 5'($urandom());
        rt = 5'($urandom());
        rd = 5'($urandom());
        imm = 16'($urandom());
        case ($urandom_range(0, 19))
            0: return {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1: return {6'h00, rs, rt, rd, 5'd0, 6'h23};
            2: return {6'h00, rs, rt, rd, 5'd0, 6'h24};
            3: return {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4: return {6'h00, rs, rt, rd, 5'd0, 6'h26};
            5: return {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            6: return {6'h00, rs, 15'd0, 6'h08};
            7: return {6'h09, rs, rt, imm};
            8: return {6'h0d, rs, rt, imm};
            // rs left random so a lui that reads rs shows up
            9: return {6'h0f, rs, rt, imm};
            10: return {6'h23, rs, rt, imm};
            11: return {6'h2b, rs, rt, imm};
            12: return {6'h04, rs, rt, imm};
            13: return {6'h05, rs, rt, imm};
            14: return {6'h02, rs, rt, imm};
            15: return {6'h03, rs, rt, imm};
            16: return {6'h10, 5'h00, rt, rd, 8'd0, imm[2:0]};
            17: return {6'h10, 5'h04, rt, rd, 8'd0, imm[2:0]};
            18: return {6'h1c, rs, rt, imm};
            default: return {6'h00, rs, rt, rd, 5'd0, 6'h3f};
        endcase
    endfunction

    task automatic comparePair(input decodedPair got, input decodedPair exp);
        string ln;
        for (int i = 1; i >= 0; i--) begin
            ln = $sformatf("decPair[%0d].", i);
            checkField({ln, "valid"}, got[i].valid, exp[i].valid);
            checkField({ln, "pc"}, got[i].pc, exp[i].pc);
            checkField({ln, "rawInstr"}, got[i].rawInstr, exp[i].rawInstr);
            checkField({ln, "imm"}, got[i].imm, exp[i].imm);
            checkField({ln, "cp0ra"}, got[i].cp0ra, exp[i].cp0ra);
            checkField({ln, "ra1"}, got[i].ra1, exp[i].ra1);
            checkField({ln, "ra2"}, got[i].ra2, exp[i].ra2);
            checkField({ln, "rdst"}, got[i].rdst, exp[i].rdst);
            checkField({ln, "isSlot"}, got[i].isSlot, exp[i].isSlot);
            checkField({ln, "ctl"}, got[i].ctl, exp[i].ctl);
        end
    endtask

    // fetch unit sends only against held credits
    always @(posedge clk) begin : fetchDriver
        fetchPacket p;
        fetchValid <= 1'b0;
        if (driveOn && fetchCreditsTb > 0 && accepted < numPkts &&
                (stallPhase || $urandom_range(0, 2) != 0)) begin
            p.pc = $urandom() & 32'hffff_fff8;
            p.instr[1] = randInstr();
            p.instr[0] = randInstr();
            p.laneValid = 2'($urandom());
            fetchValid <= 1'b1;
            fetchPc <= p.pc;
            fetchInstr1 <= p.instr[1];
            fetchInstr0 <= p.instr[0];
            fetchLaneValid <= p.laneValid;
            expQ.push_back(refDecode(p));
            fetchCreditsTb--;
            accepted++;
        end
    end

    // issue-side consumer hands credits back after random delays
    always @(posedge clk) begin
        decCredit <= 1'b0;
        if (returnOn && pendingReturns > 0 && $urandom_range(0, 3) == 0) begin
            decCredit <= 1'b1;
            pendingReturns--;
            outCreditsTb++;
        end
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            assert (!decValid && !fetchCredit)
            else failRun("decValid or fetchCredit high during reset");
        end else begin
            if (fetchCredit) begin
                fetchPulses++;
                fetchCreditsTb++;
            end
            if (decValid) begin
                assert (outCreditsTb > 0)
                else failRun("decValid high while the consumer held no credit");
                assert (expQ.size() > 0)
                else failRun("decoded pair appeared with no packet outstanding");
                comparePair(decPair, expQ.pop_front());
                outCreditsTb--;
                pendingReturns++;
                matched++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles < timeoutCycles)
        else failRun("timeout, decoded pairs stopped arriving");
    end

    initial begin
        void'($urandom(42));
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        driveOn <= 1'b1;
        // no consumer credits returned yet so the pipeline fills and stalls
        repeat (stallCycles) @(posedge clk);
        @(negedge clk);
        checkField("accepted", accepted, `FQ_DEPTH + `DEC_DEPTH + `OUT_CREDITS);
        checkField("matched", matched, `OUT_CREDITS);
        checkField("fetchCreditsTb", fetchCreditsTb, 0);
        @(posedge clk);
        stallPhase <= 1'b0;
        returnOn <= 1'b1;
        wait (matched == numPkts);
        checkField("expQ.size", expQ.size(), 0);
        assert (fetchPulses == accepted) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            failRun($sformatf("CHECK FAILED fetchCredit pulses 0x%0h expected 0x%0h",
                              fetchPulses, accepted));
        end
    end

endmodule

// File: files.f
+incdir+.
cpuPkg.sv
slotIf.sv
creditFifo.sv
instrDecoder.sv
dualDecode.sv
decodeStage.sv
decodeTop.sv
tbDecodeTop.sv

// File: Bender.yml
package:
  name: decode_top

export_include_dirs:
  - .

sources:
  - cpuPkg.sv
  - slotIf.sv
  - creditFifo.sv
  - instrDecoder.sv
  - dualDecode.sv
  - decodeStage.sv
  - decodeTop.sv
  - target: simulation
    files:
      - tbDecodeTop.sv
